// ==== sim.f ====
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_commit_stage.sv
csr_regfile.sv
csr_timer.sv
csr_unit.sv
tb_clock.sv
csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

export_include_dirs:
  - .

sources:
  - files:
      - csr_pkg.sv
      - csr_decode.sv
      - csr_commit_stage.sv
      - csr_regfile.sv
      - csr_timer.sv
      - csr_unit.sv
  - target: test
    files:
      - tb_clock.sv
      - csr_unit_tb.sv

// ==== csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_config.svh"

module csr_unit_tb
    import csr_pkg::*;
();
    localparam int          PERIOD     = 20;
    localparam int          TIMER_INIT = 64;
    localparam logic [31:0] EENTRY_VAL = 32'h1c00_8000;
    localparam logic [31:0] LATE_PC    = 32'h1c00_0a44;
    localparam logic [31:0] LATE_VADDR = 32'h0000_5678;
    localparam logic [5:0]  ECODE_SYS  = 6'h0b;
    localparam logic [8:0]  CRMD_DA    = 9'h008;

    typedef struct packed {
        csr_op_e        op;
        logic [15:0]    info;
        logic [31:0]    din;
        logic [31:0]    mask;
        logic [31:0]    pc;
        logic [31:0]    evaddr;
        csr_late_excp_t late;
        logic           kill;
        logic [8:0]     int_lines;
        logic           exp_flush;
        logic [31:0]    exp_redirect;
        logic [31:0]    exp_rdata;
        logic [8:0]     exp_crmd;
    } step_t;

    logic           clk;
    logic           rstn;
    csr_req_t       req;
    csr_late_excp_t late_excp;
    logic           stall;
    logic           kill;
    logic [8:0]     int_lines;
    logic           flush;
    logic [31:0]    redirect_pc;
    logic [31:0]    rdata;
    logic [8:0]     crmd;

    step_t       table_q[$];
    logic [31:0] pc_next;
    logic [31:0] era_exp;
    logic [31:0] save_val [4];
    int          split_at;
    int          limit_cycles;

    tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(5)) clk_gen (.clk(clk), .rstn(rstn));

    csr_unit dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .late_excp   (late_excp),
        .stall       (stall),
        .kill        (kill),
        .int_lines   (int_lines),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .rdata       (rdata),
        .crmd        (crmd)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic add_row(input csr_op_e op, input logic [15:0] info,
                           input logic [31:0] din, input logic [31:0] mask,
                           input csr_late_excp_t late, input logic kl,
                           input logic exp_flush, input logic [31:0] exp_redirect,
                           input logic [31:0] exp_rdata, input logic [8:0] exp_crmd);
        step_t s;
        s.op           = op;
        s.info         = info;
        s.din          = din;
        s.mask         = mask;
        s.pc           = pc_next;
        s.evaddr       = 32'h0;
        s.late         = late;
        s.kill         = kl;
        s.int_lines    = 9'h0;
        s.exp_flush    = exp_flush;
        s.exp_redirect = exp_redirect;
        s.exp_rdata    = exp_rdata;
        s.exp_crmd     = exp_crmd;
        table_q.push_back(s);
        pc_next = pc_next + 32'd8;
    endtask

    // writes flush to the next instruction, reads do not flush
    task automatic access(input csr_op_e op, input logic [15:0] num, input logic [31:0] din,
                          input logic [31:0] mask, input logic [31:0] exp_rdata,
                          input logic [8:0] exp_crmd);
        logic writes;
        writes = (op == OP_CSRWR) || (op == OP_CSRXCHG);
        add_row(op, num, din, mask, '0, 1'b0, writes, writes ? pc_next + 32'd4 : 32'd0,
                exp_rdata, exp_crmd);
    endtask

    task automatic raise_excp(input logic [5:0] ecode, input logic [8:0] exp_crmd);
        era_exp = pc_next;
        add_row(OP_EXCP, {1'b1, 9'h000, ecode}, 32'h0, 32'h0, '0, 1'b0, 1'b1, EENTRY_VAL,
                32'h0, exp_crmd);
    endtask

    task automatic build_table();
        csr_late_excp_t late;
        logic [31:0]    d;
        logic [31:0]    m;
        d = $urandom;
        m = $urandom;
        access(OP_CSRRD, `CSR_ADDR_CRMD, 32'h0, 32'h0, 32'h8, CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_SAVE0, 32'h0, 32'h0, 32'h0, CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_TVAL, 32'h0, 32'h0, 32'h0, CRMD_DA);
        access(OP_CSRWR, `CSR_ADDR_EENTRY, EENTRY_VAL, '1, 32'h0, CRMD_DA);
        for (int k = 0; k < 4; k++)
            access(OP_CSRWR, `CSR_ADDR_SAVE0 + k[15:0], save_val[k], '1, 32'h0, CRMD_DA);
        for (int k = 0; k < 4; k++)
            access(OP_CSRRD, `CSR_ADDR_SAVE0 + k[15:0], 32'h0, 32'h0, save_val[k], CRMD_DA);
        access(OP_CSRXCHG, `CSR_ADDR_SAVE2, d, m, save_val[2], CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_SAVE2, 32'h0, 32'h0, (save_val[2] & ~m) | (d & m), CRMD_DA);

        // PLV3 with IE, then a syscall and the return
        access(OP_CSRWR, `CSR_ADDR_CRMD, 32'h0f, '1, 32'h8, 9'h00f);
        raise_excp(ECODE_SYS, CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_ESTAT, 32'h0, 32'h0, {10'h0, ECODE_SYS, 16'h0}, CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_ERA, 32'h0, 32'h0, era_exp, CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_PRMD, 32'h0, 32'h0, 32'h7, CRMD_DA);
        add_row(OP_ERTN, 16'h0, 32'h0, 32'h0, '0, 1'b0, 1'b1, era_exp, 32'h0, 9'h00f);

        // fetch address error from the next stage beats the write
        late             = '0;
        late.info.excp.valid    = 1'b1;
        late.info.excp.ecode    = `CSR_ECODE_ADE;
        late.info.excp.esubcode = `CSR_ESUB_ADEF;
        late.pc          = LATE_PC;
        late.evaddr      = LATE_VADDR;
        add_row(OP_CSRWR, `CSR_ADDR_SAVE0, ~save_val[0], '1, late, 1'b0, 1'b1, EENTRY_VAL,
                32'h0, CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_SAVE0, 32'h0, 32'h0, save_val[0], CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_BADV, 32'h0, 32'h0, LATE_PC, CRMD_DA);

        add_row(OP_CSRWR, `CSR_ADDR_SAVE1, ~save_val[1], '1, '0, 1'b1, 1'b0, 32'h0, 32'h0,
                CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_SAVE1, 32'h0, 32'h0, save_val[1], CRMD_DA);

        // timer interrupt on LIE bit 11
        access(OP_CSRWR, `CSR_ADDR_ECFG, 32'h800, '1, 32'h0, CRMD_DA);
        access(OP_CSRWR, `CSR_ADDR_CRMD, 32'h0c, '1, 32'h8, 9'h00c);
        access(OP_CSRWR, `CSR_ADDR_TCFG, TIMER_INIT | 1, '1, 32'h0, 9'h00c);
        split_at = table_q.size();
        access(OP_CSRRD, `CSR_ADDR_ESTAT, 32'h0, 32'h0, 32'h800, CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_PRMD, 32'h0, 32'h0, 32'h4, CRMD_DA);
        access(OP_CSRWR, `CSR_ADDR_TICLR, 32'h1, '1, 32'h0, CRMD_DA);
        access(OP_CSRRD, `CSR_ADDR_ESTAT, 32'h0, 32'h0, 32'h0, CRMD_DA);
    endtask

    task automatic drive_idle();
        req       = '0;
        late_excp = '0;
        kill      = 1'b0;
        int_lines = 9'h0;
    endtask

    task automatic apply_row(input step_t s, input int idx);
        string tag;
        tag = $sformatf("row %0d", idx);
        req.op               = s.op;
        req.info.csr_num     = s.info;
        req.din              = s.din;
        req.mask             = s.mask;
        req.pc               = s.pc;
        req.evaddr           = s.evaddr;
        late_excp            = s.late;
        kill                 = s.kill;
        int_lines            = s.int_lines;
        @(posedge clk);
        #1;
        drive_idle();
        check_value({tag, " flush"}, flush, s.exp_flush);
        check_value({tag, " redirect_pc"}, redirect_pc, s.exp_redirect);
        check_value({tag, " rdata"}, rdata, s.exp_rdata);
        @(posedge clk);
        #1;
        check_value({tag, " crmd"}, crmd, s.exp_crmd);
    endtask

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the tests did not complete within %0d cycles", limit_cycles);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        limit_cycles = 0;
        pc_next      = 32'h1c00_0000;
        era_exp      = 32'h0;
        stall        = 1'b0;
        drive_idle();
        void'($urandom(14));
        for (int k = 0; k < 4; k++)
            save_val[k] = $urandom;
        build_table();
        limit_cycles = table_q.size() * 4 + TIMER_INIT * 2 + 10;

        wait (rstn === 1'b1);
        check_value("reset flush", flush, 1'b0);
        check_value("reset redirect_pc", redirect_pc, 32'h0);
        check_value("reset rdata", rdata, 32'h0);
        check_value("reset crmd", crmd, CRMD_DA);

        for (int i = 0; i < split_at; i++)
            apply_row(table_q[i], i);

        // no fixed latency for the timer
        while (flush !== 1'b1)
        begin
            @(posedge clk);
            #1;
        end
        check_value("interrupt redirect_pc", redirect_pc, EENTRY_VAL);
        @(posedge clk);
        #1;
        check_value("interrupt crmd", crmd, CRMD_DA);

        for (int i = split_at; i < table_q.size(); i++)
            apply_row(table_q[i], i);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rstn
);
    initial
    begin
        clk  = 1'b0;
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_config.svh"

module csr_unit
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_req_t             req,
    input  csr_late_excp_t       late_excp,
    input  logic                 stall,
    input  logic                 kill,
    input  logic [8:0]           int_lines,
    output logic                 flush,
    output logic [`CSR_XLEN-1:0] redirect_pc,
    output logic [`CSR_XLEN-1:0] rdata,
    output logic [8:0]           crmd
);
    csr_commit_t             dec_commit;
    csr_resp_t               dec_resp;
    csr_commit_t             cmt_commit;
    csr_resp_t               cmt_resp;
    csr_state_t              state;
    logic [`CSR_TIMER_N-1:0] tcfg;
    logic [`CSR_TIMER_N-1:0] tval;
    logic                    ticlr_wr;
    logic                    ti;
    logic                    irq_taken;

    // only an interrupt produces a valid INT commit
    assign irq_taken = dec_commit.valid && (dec_commit.op == OP_EXCP)
                       && (dec_commit.ecode == `CSR_ECODE_INT);

    csr_decode u_decode (
        .req       (req),
        .late_excp (late_excp),
        .stall     (stall),
        .kill      (kill),
        .int_lines (int_lines),
        .state     (state),
        .ti        (ti),
        .commit    (dec_commit),
        .resp      (dec_resp)
    );

    csr_commit_stage u_stage (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .irq_taken  (irq_taken),
        .kill       (kill),
        .commit_in  (dec_commit),
        .resp_in    (dec_resp),
        .commit_out (cmt_commit),
        .resp_out   (cmt_resp)
    );

    csr_regfile u_regfile (
        .clk      (clk),
        .rstn     (rstn),
        .commit   (cmt_commit),
        .tval     (tval),
        .state    (state),
        .crmd     (crmd),
        .tcfg     (tcfg),
        .ticlr_wr (ticlr_wr)
    );

    csr_timer u_timer (
        .clk      (clk),
        .rstn     (rstn),
        .tcfg     (tcfg),
        .ticlr_wr (ticlr_wr),
        .tval     (tval),
        .ti       (ti)
    );

    assign flush       = cmt_resp.flush;
    assign redirect_pc = cmt_resp.redirect_pc;
    assign rdata       = cmt_resp.rdata;

endmodule

`default_nettype wire

// ==== csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_config.svh"

module csr_timer (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`CSR_TIMER_N-1:0] tcfg,
    input  logic                    ticlr_wr,
    output logic [`CSR_TIMER_N-1:0] tval,
    output logic                    ti
);
    logic                    en;
    logic                    periodic;
    logic [`CSR_TIMER_N-1:0] init_val;
    logic                    reload;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign init_val = {tcfg[`CSR_TIMER_N-1:2], 2'b00};
    // one-shot waits for ti to be cleared before arming again
    assign reload   = (tval == '0) && (periodic || (en && !ti));

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval <= '0;
            ti   <= 1'b0;
        end
        else
        begin
            if (ticlr_wr)
                ti <= 1'b0;
            else if (tval == `CSR_TIMER_N'd1)
                ti <= 1'b1;

            if (reload)
                tval <= init_val;
            else if (en && tval != '0)
                tval <= tval - `CSR_TIMER_N'd1;
        end
    end

    // tval only ever goes up by a reload to the initial value
    assert property (@(posedge clk) disable iff (!rstn)
        (tval > $past(tval)) |-> (tval == {$past(tcfg[`CSR_TIMER_N-1:2]), 2'b00}));

endmodule

`default_nettype wire

// ==== csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_config.svh"

module csr_regfile
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  csr_commit_t             commit,
    input  logic [`CSR_TIMER_N-1:0] tval,
    output csr_state_t              state,
    output logic [8:0]              crmd,
    output logic [`CSR_TIMER_N-1:0] tcfg,
    output logic                    ticlr_wr
);
    csr_state_t           r;
    logic                 csr_wr;
    logic [`CSR_XLEN-1:0] w;

    assign csr_wr   = commit.valid && (commit.op == OP_CSRWR || commit.op == OP_CSRXCHG);
    assign w        = commit.wdata;
    assign ticlr_wr = csr_wr && (commit.csr_num == `CSR_ADDR_TICLR) && w[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            r      <= '0;
            r.crmd <= `CSR_CRMD_RESET;
        end
        else if (commit.valid)
        begin
            case (commit.op)
                OP_ERTN:
                begin
                    // only PLV and IE come back
                    r.crmd[2:0] <= r.prmd;
                end
                OP_EXCP:
                begin
                    r.prmd      <= r.crmd[2:0];
                    r.crmd[2:0] <= 3'b000;
                    r.era       <= commit.era;
                    r.badv      <= commit.badv;
                    r.ecode     <= commit.ecode;
                    r.esubcode  <= commit.esubcode;
                end
                OP_CSRWR, OP_CSRXCHG:
                begin
                    case (commit.csr_num)
                        `CSR_ADDR_CRMD:
                        begin
                            r.crmd[2:0] <= w[2:0];
                            r.crmd[8:5] <= w[8:5];
                            // DA and PG must stay one-hot
                            if (w[4] ^ w[3])
                                r.crmd[4:3] <= w[4:3];
                        end
                        `CSR_ADDR_PRMD:   r.prmd     <= w[2:0];
                        `CSR_ADDR_EUEN:   r.euen     <= w[0];
                        `CSR_ADDR_ECFG:   r.ecfg_lie <= {w[12:11], 1'b0, w[9:0]};
                        `CSR_ADDR_ESTAT:  r.estat_is <= w[1:0];
                        `CSR_ADDR_ERA:    r.era      <= w;
                        `CSR_ADDR_BADV:   r.badv     <= w;
                        `CSR_ADDR_EENTRY: r.eentry   <= w[31:6];
                        `CSR_ADDR_SAVE0:  r.save0    <= w;
                        `CSR_ADDR_SAVE1:  r.save1    <= w;
                        `CSR_ADDR_SAVE2:  r.save2    <= w;
                        `CSR_ADDR_SAVE3:  r.save3    <= w;
                        `CSR_ADDR_TID:    r.tid      <= w;
                        `CSR_ADDR_TCFG:   r.tcfg     <= w[`CSR_TIMER_N-1:0];
                        default:
                        begin
                            r.euen <= r.euen;
                        end
                    endcase
                end
                default:
                begin
                    r.euen <= r.euen;
                end
            endcase
        end
    end

    // tval lives in the timer
    always_comb
    begin
        state      = r;
        state.tval = tval;
    end

    assign crmd = r.crmd;
    assign tcfg = r.tcfg;

    // TVAL is read only to software
    assert property (@(posedge clk) disable iff (!rstn)
        csr_wr |-> commit.csr_num != `CSR_ADDR_TVAL);

endmodule

`default_nettype wire

// ==== csr_commit_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_commit_stage
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        stall,
    input  logic        irq_taken,
    input  logic        kill,
    input  csr_commit_t commit_in,
    input  csr_resp_t   resp_in,
    output csr_commit_t commit_out,
    output csr_resp_t   resp_out
);
    logic        valid_q;
    logic        excp_out;
    csr_resp_t   resp_q;
    csr_commit_t data_q;

    // decode still sees the old CRMD.IE while an exception sits here
    // so whatever it offers in that cycle is dropped
    assign excp_out = valid_q && (data_q.op == OP_EXCP);

    // valid and resp last one cycle; a held operation is not replayed
    always_ff @(posedge clk)
    begin
        if (!rstn || excp_out || ((kill || stall) && !irq_taken))
        begin
            valid_q <= 1'b0;
            resp_q  <= '0;
        end
        else
        begin
            valid_q <= commit_in.valid;
            resp_q  <= resp_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall || irq_taken)
            data_q <= commit_in;
    end

    always_comb
    begin
        commit_out       = data_q;
        commit_out.valid = valid_q;
    end

    assign resp_out = resp_q;

    // a redirect must always come with the commit that caused it
    assert property (@(posedge clk) disable iff (!rstn)
        resp_out.flush |-> commit_out.valid);

endmodule

`default_nettype wire

// ==== csr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "csr_config.svh"

module csr_decode
    import csr_pkg::*;
(
    input  csr_req_t       req,
    input  csr_late_excp_t late_excp,
    input  logic           stall,
    input  logic           kill,
    input  logic [8:0]     int_lines,
    input  csr_state_t     state,
    input  logic           ti,
    output csr_commit_t    commit,
    output csr_resp_t      resp
);
    localparam int PAD_T = `CSR_XLEN - `CSR_TIMER_N;

    logic [12:0]          int_vec;
    logic                 irq;
    logic                 take;
    csr_op_e              op;
    logic [5:0]           ecode;
    logic [8:0]           esubcode;
    logic [`CSR_XLEN-1:0] pc;
    logic [`CSR_XLEN-1:0] evaddr;
    logic [`CSR_XLEN-1:0] old_val;
    logic [`CSR_XLEN-1:0] wmask;
    logic [`CSR_XLEN-1:0] estat_val;

    // same bit order as ESTAT[12:0], bit 10 reserved
    assign int_vec   = {int_lines[8], ti, 1'b0, int_lines[7:0], state.estat_is};
    assign irq       = (|(int_vec & state.ecfg_lie)) && state.crmd[2];
    assign estat_val = {1'b0, state.esubcode, state.ecode, 3'b000, int_vec};
    assign wmask     = (req.op == OP_CSRXCHG) ? req.mask : '1;

    // interrupt, then late exception, then the request itself
    always_comb
    begin
        op       = req.op;
        ecode    = req.info.excp.ecode;
        esubcode = req.info.excp.esubcode;
        pc       = req.pc;
        evaddr   = req.evaddr;
        take     = (req.op != OP_NONE) && !stall && !kill;
        if (irq)
        begin
            op       = OP_EXCP;
            ecode    = `CSR_ECODE_INT;
            esubcode = '0;
            take     = 1'b1;
        end
        else if (late_excp.info.excp.valid)
        begin
            op       = OP_EXCP;
            ecode    = late_excp.info.excp.ecode;
            esubcode = late_excp.info.excp.esubcode;
            pc       = late_excp.pc;
            evaddr   = late_excp.evaddr;
            take     = !stall && !kill;
        end
    end

    always_comb
    begin
        case (req.info.csr_num)
            `CSR_ADDR_CRMD:   old_val = {23'b0, state.crmd};
            `CSR_ADDR_PRMD:   old_val = {29'b0, state.prmd};
            `CSR_ADDR_EUEN:   old_val = {31'b0, state.euen};
            `CSR_ADDR_ECFG:   old_val = {19'b0, state.ecfg_lie};
            `CSR_ADDR_ESTAT:  old_val = estat_val;
            `CSR_ADDR_ERA:    old_val = state.era;
            `CSR_ADDR_BADV:   old_val = state.badv;
            `CSR_ADDR_EENTRY: old_val = {state.eentry, 6'b0};
            `CSR_ADDR_SAVE0:  old_val = state.save0;
            `CSR_ADDR_SAVE1:  old_val = state.save1;
            `CSR_ADDR_SAVE2:  old_val = state.save2;
            `CSR_ADDR_SAVE3:  old_val = state.save3;
            `CSR_ADDR_TID:    old_val = state.tid;
            `CSR_ADDR_TCFG:   old_val = {{PAD_T{1'b0}}, state.tcfg};
            `CSR_ADDR_TVAL:   old_val = {{PAD_T{1'b0}}, state.tval};
            // CPUID and TICLR read as zero
            default:          old_val = '0;
        endcase
    end

    always_comb
    begin
        commit.valid    = take;
        commit.op       = op;
        commit.csr_num  = req.info.csr_num;
        commit.wdata    = (old_val & ~wmask) | (req.din & wmask);
        commit.ecode    = ecode;
        commit.esubcode = esubcode;
        commit.era      = pc;
        // fetch address error reports the pc itself
        if (ecode == `CSR_ECODE_ADE && esubcode == `CSR_ESUB_ADEF)
            commit.badv = pc;
        else
            commit.badv = evaddr;

        resp = '0;
        if (take)
        begin
            case (op)
                OP_CSRRD:
                begin
                    resp.rdata = old_val;
                end
                OP_CSRWR, OP_CSRXCHG:
                begin
                    resp.flush       = 1'b1;
                    resp.redirect_pc = pc + `CSR_XLEN'd4;
                    resp.rdata       = old_val;
                end
                OP_ERTN:
                begin
                    resp.flush       = 1'b1;
                    resp.redirect_pc = state.era;
                end
                OP_EXCP:
                begin
                    resp.flush       = 1'b1;
                    resp.redirect_pc = {state.eentry, 6'b0};
                end
                default:
                begin
                    resp.flush = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== csr_pkg.sv ====
`default_nettype none
`include "csr_config.svh"

package csr_pkg;

    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_CSRRD   = 3'd1,
        OP_CSRWR   = 3'd2,
        OP_CSRXCHG = 3'd3,
        OP_ERTN    = 3'd4,
        OP_EXCP    = 3'd5
    } csr_op_e;

    // exception view of the argument word
    typedef struct packed {
        logic       valid;
        logic [8:0] esubcode;
        logic [5:0] ecode;
    } excp_arg_t;

    typedef union packed {
        logic [15:0] csr_num;
        excp_arg_t   excp;
    } excp_info_u;

    typedef struct packed {
        csr_op_e              op;
        excp_info_u           info;
        logic [`CSR_XLEN-1:0] din;
        logic [`CSR_XLEN-1:0] mask;
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] evaddr;
    } csr_req_t;

    // valid is info.excp.valid
    typedef struct packed {
        excp_info_u           info;
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] evaddr;
    } csr_late_excp_t;

    typedef struct packed {
        logic                 valid;
        csr_op_e              op;
        logic [15:0]          csr_num;
        logic [`CSR_XLEN-1:0] wdata;
        logic [5:0]           ecode;
        logic [8:0]           esubcode;
        logic [`CSR_XLEN-1:0] era;
        logic [`CSR_XLEN-1:0] badv;
    } csr_commit_t;

    typedef struct packed {
        logic                 flush;
        logic [`CSR_XLEN-1:0] redirect_pc;
        logic [`CSR_XLEN-1:0] rdata;
    } csr_resp_t;

    typedef struct packed {
        logic [8:0]              crmd;
        logic [2:0]              prmd;
        logic                    euen;
        logic [12:0]             ecfg_lie;
        logic [1:0]              estat_is;
        logic [5:0]              ecode;
        logic [8:0]              esubcode;
        logic [`CSR_XLEN-1:0]    era;
        logic [`CSR_XLEN-1:0]    badv;
        logic [31:6]             eentry;
        logic [`CSR_XLEN-1:0]    save0;
        logic [`CSR_XLEN-1:0]    save1;
        logic [`CSR_XLEN-1:0]    save2;
        logic [`CSR_XLEN-1:0]    save3;
        logic [`CSR_XLEN-1:0]    tid;
        logic [`CSR_TIMER_N-1:0] tcfg;
        logic [`CSR_TIMER_N-1:0] tval;
    } csr_state_t;

endpackage

`default_nettype wire

// ==== csr_config.svh ====
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

`define CSR_XLEN            32
`define CSR_TIMER_N         20

// CSR numbers, as seen in the 16-bit argument word
`define CSR_ADDR_CRMD       16'h0000
`define CSR_ADDR_PRMD       16'h0001
`define CSR_ADDR_EUEN       16'h0002
`define CSR_ADDR_ECFG       16'h0004
`define CSR_ADDR_ESTAT      16'h0005
`define CSR_ADDR_ERA        16'h0006
`define CSR_ADDR_BADV       16'h0007
`define CSR_ADDR_EENTRY     16'h000C
`define CSR_ADDR_CPUID      16'h0020
`define CSR_ADDR_SAVE0      16'h0030
`define CSR_ADDR_SAVE1      16'h0031
`define CSR_ADDR_SAVE2      16'h0032
`define CSR_ADDR_SAVE3      16'h0033
`define CSR_ADDR_TID        16'h0040
`define CSR_ADDR_TCFG       16'h0041
`define CSR_ADDR_TVAL       16'h0042
`define CSR_ADDR_TICLR      16'h0044

`define CSR_ECODE_INT       6'h00
`define CSR_ECODE_ADE       6'h08
`define CSR_ESUB_ADEF       9'h000

// DA set, PG clear, PLV0, interrupts off
`define CSR_CRMD_RESET      9'h008

`endif
